//--- gfp8_bcv.f
+incdir+tests
verilog/gfp8_bcv_pkg.sv
verilog/bcv_loop_sequencer.sv
verilog/nv_fetch.sv
verilog/nv_dot_pipe.sv
verilog/vloop_accumulator.sv
verilog/gfp8_bcv_top.sv
tests/tb_gfp8_bcv.sv

//--- tests/tb_gfp8_bcv_model.svh
/*
 * GFP8 BCV testbench model
 * Tile memory contents and the reference dot product and V-loop
 * accumulation that give the expected result of every (b,c) pair
 */

// Tile memory, one whole NV per entry
logic [EXP_W-1:0] mem_exp [128];
logic [MAN_W-1:0] mem_man [128];

// Expected results in b-major, c-minor order
mant_t exp_man_q [$];
gexp_t exp_exp_q [$];

// Random small exponents, random mantissa bytes
function automatic void fill_memory();
    for (int i = 0; i < 128; i++) begin
        for (int g = 0; g < NV_GROUPS; g++) begin
            mem_exp[i][g*8 +: 8] = 8'($urandom_range(15, 0) - 8);
        end
        for (int w = 0; w < MAN_W / 32; w++) begin
            mem_man[i][w*32 +: 32] = $urandom();
        end
    end
endfunction

// Sum at the larger exponent, far smaller operand flushes to zero
function automatic void aligned_sum(
    input  mant_t a_man,
    input  gexp_t a_exp,
    input  mant_t b_man,
    input  gexp_t b_exp,
    output mant_t s_man,
    output gexp_t s_exp
);
    gexp_t      top;
    logic [7:0] dist_a;
    logic [7:0] dist_b;

    top = (a_exp > b_exp) ? a_exp : b_exp;
    dist_a = top - a_exp;
    dist_b = top - b_exp;
    s_man = ((dist_a > 8'd31) ? 32'sd0 : (a_man >>> dist_a))
          + ((dist_b > 8'd31) ? 32'sd0 : (b_man >>> dist_b));
    s_exp = top;
endfunction

// Group sums of products, folded from group 0 upward
function automatic void nv_dot(input int li, input int ri, output mant_t d_man, output gexp_t d_exp);
    mant_t gsum;
    gexp_t gexp;
    elem_t a;
    elem_t b;

    for (int g = 0; g < NV_GROUPS; g++) begin
        gsum = '0;
        for (int e = 0; e < GROUP_ELEMS; e++) begin
            a = mem_man[li][(g*GROUP_ELEMS+e)*8 +: 8];
            b = mem_man[ri][(g*GROUP_ELEMS+e)*8 +: 8];
            gsum = gsum + mant_t'(a) * mant_t'(b);
        end
        gexp = mem_exp[li][g*8 +: 8] + mem_exp[ri][g*8 +: 8];
        if (g == 0) begin
            d_man = gsum;
            d_exp = gexp;
        end else begin
            aligned_sum(d_man, d_exp, gsum, gexp, d_man, d_exp);
        end
    end
endfunction

// Queue the B*C expected results of one tile
function automatic void expect_tile(
    input dim_t       b_dim,
    input dim_t       c_dim,
    input dim_t       v_dim,
    input line_addr_t l_base,
    input line_addr_t r_base
);
    int    li;
    int    ri;
    mant_t acc_man;
    gexp_t acc_exp;
    mant_t dot_man;
    gexp_t dot_exp;

    for (int b = 0; b < int'(b_dim); b++) begin
        for (int c = 0; c < int'(c_dim); c++) begin
            for (int v = 0; v < int'(v_dim); v++) begin
                // Base in lines, four lines per NV, 128 NVs
                li = (int'(l_base) / 4 + b * int'(v_dim) + v) % 128;
                ri = (int'(r_base) / 4 + c * int'(v_dim) + v) % 128;
                nv_dot(li, ri, dot_man, dot_exp);
                if (v == 0) begin
                    acc_man = dot_man;
                    acc_exp = dot_exp;
                end else begin
                    aligned_sum(acc_man, acc_exp, dot_man, dot_exp, acc_man, acc_exp);
                end
            end
            exp_man_q.push_back(acc_man);
            exp_exp_q.push_back(acc_exp);
        end
    end
endfunction

//--- tests/tb_gfp8_bcv.sv
/*
 * GFP8 BCV tile engine testbench
 * Applies a table of tile commands against a random tile memory,
 * checks every result against the model, the done pulse, the reset
 * state and that a held enable starts only one tile
 */
`timescale 1ns/1ps
`default_nettype none

module tb_gfp8_bcv
    import gfp8_bcv_pkg::*;
();

    localparam int NV_GROUPS    = 4;
    localparam int GROUP_ELEMS  = 32;
    localparam int EXP_W        = NV_GROUPS * 8;
    localparam int MAN_W        = NV_GROUPS * GROUP_ELEMS * 8;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY  = 2;
    localparam int IDLE_GAP     = 20;
    localparam int NUM_CMDS     = 6;

    logic             i_clk;
    logic             i_reset_n;
    logic             i_tile_en;
    dim_t             i_dim_b;
    dim_t             i_dim_c;
    dim_t             i_dim_v;
    line_addr_t       i_left_base_addr;
    line_addr_t       i_right_base_addr;
    logic             o_tile_done;
    nv_idx_t          o_nv_left_rd_idx;
    nv_idx_t          o_nv_right_rd_idx;
    logic [EXP_W-1:0] i_nv_left_exp;
    logic [EXP_W-1:0] i_nv_right_exp;
    logic [MAN_W-1:0] i_nv_left_man;
    logic [MAN_W-1:0] i_nv_right_man;
    mant_t            o_result_mantissa;
    gexp_t            o_result_exponent;
    logic             o_result_valid;

    `include "tb_gfp8_bcv_model.svh"

    // Tile command: dimensions, base lines, enable hold in cycles
    typedef struct {
        dim_t       b;
        dim_t       c;
        dim_t       v;
        line_addr_t lbase;
        line_addr_t rbase;
        int         hold;
    } tile_cmd_t;

    tile_cmd_t cmd_table [NUM_CMDS];

    int checks;
    int value_errors;
    int other_errors;
    int result_count;
    int done_count;
    int cycle_count;
    int timeout_limit;
    logic prev_valid;

    gfp8_bcv_top #(
        .NV_GROUPS   (NV_GROUPS),
        .GROUP_ELEMS (GROUP_ELEMS)
    ) dut_i (
        .i_clk             (i_clk),
        .i_reset_n         (i_reset_n),
        .i_tile_en         (i_tile_en),
        .i_dim_b           (i_dim_b),
        .i_dim_c           (i_dim_c),
        .i_dim_v           (i_dim_v),
        .i_left_base_addr  (i_left_base_addr),
        .i_right_base_addr (i_right_base_addr),
        .o_tile_done       (o_tile_done),
        .o_nv_left_rd_idx  (o_nv_left_rd_idx),
        .i_nv_left_exp     (i_nv_left_exp),
        .i_nv_left_man     (i_nv_left_man),
        .o_nv_right_rd_idx (o_nv_right_rd_idx),
        .i_nv_right_exp    (i_nv_right_exp),
        .i_nv_right_man    (i_nv_right_man),
        .o_result_mantissa (o_result_mantissa),
        .o_result_exponent (o_result_exponent),
        .o_result_valid    (o_result_valid)
    );

    // Memory answers the registered indices combinationally
    assign i_nv_left_exp  = mem_exp[o_nv_left_rd_idx];
    assign i_nv_left_man  = mem_man[o_nv_left_rd_idx];
    assign i_nv_right_exp = mem_exp[o_nv_right_rd_idx];
    assign i_nv_right_man = mem_man[o_nv_right_rd_idx];

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    // ====================
    // Compare tasks
    // ====================
    task automatic check_mantissa(input string name, input mant_t got, input mant_t want);
        checks++;
        if (got !== want) begin
            value_errors++;
            $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, want);
        end
    endtask

    task automatic check_exponent(input string name, input gexp_t got, input gexp_t want);
        checks++;
        if (got !== want) begin
            value_errors++;
            $display("Fail %s: got 0x%02h, expected 0x%02h", name, got, want);
        end
    endtask

    task automatic check_count(input string name, input int got, input int want);
        checks++;
        if (got !== want) begin
            value_errors++;
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, want);
        end
    endtask

    task automatic check_index(input string name, input nv_idx_t got, input nv_idx_t want);
        checks++;
        if (got !== want) begin
            value_errors++;
            $display("Fail %s: got 0x%02h, expected 0x%02h", name, got, want);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        checks++;
        if (got !== want) begin
            value_errors++;
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, want);
        end
    endtask

    // Outputs that must sit at zero around reset
    task automatic check_quiet_outputs();
        check_flag("o_result_valid", o_result_valid, 1'b0);
        check_flag("o_tile_done", o_tile_done, 1'b0);
        check_index("o_nv_left_rd_idx", o_nv_left_rd_idx, '0);
        check_index("o_nv_right_rd_idx", o_nv_right_rd_idx, '0);
    endtask

    // ====================
    // Command table
    // ====================
    task automatic load_commands();
        // Single pair with group alignment and group underflow
        cmd_table[0] = '{8'd1, 8'd1, 8'd1, 9'd0, 9'd4, 1};
        // V=4 accumulation across a large exponent step
        cmd_table[1] = '{8'd1, 8'd1, 8'd4, 9'd8, 9'd40, 2};
        cmd_table[2] = '{8'd3, 8'd2, 8'd2, 9'd80, 9'd160, 1};
        // Indices run past NV 127, left base not a multiple of four
        cmd_table[3] = '{8'd2, 8'd2, 8'd3, 9'd502, 9'd508, 3};
        // Enable held well beyond the end of the tile
        cmd_table[4] = '{8'd2, 8'd1, 8'd2, 9'd200, 9'd300, 80};
        cmd_table[5] = '{8'd1, 8'd2, 8'd1, 9'd96, 9'd120, 1};
    endtask

    function automatic int tile_bound(input tile_cmd_t cmd);
        return int'(cmd.b) * int'(cmd.c) * (8 * int'(cmd.v) + 1) + 3;
    endfunction

    task automatic run_tile(input int n);
        tile_cmd_t cmd;
        int        cycles;
        int        done_before;
        int        results_before;

        cmd = cmd_table[n];
        expect_tile(cmd.b, cmd.c, cmd.v, cmd.lbase, cmd.rbase);
        done_before = done_count;
        results_before = result_count;
        @(posedge i_clk);
        #DRIVE_DELAY;
        i_tile_en = 1'b1;
        i_dim_b = cmd.b;
        i_dim_c = cmd.c;
        i_dim_v = cmd.v;
        i_left_base_addr = cmd.lbase;
        i_right_base_addr = cmd.rbase;
        cycles = 0;
        // Hold the enable, then wait for done, timeout catches a hang
        while (cycles < cmd.hold || done_count == done_before) begin
            @(posedge i_clk);
            #DRIVE_DELAY;
            cycles++;
            if (cycles >= cmd.hold) begin
                i_tile_en = 1'b0;
            end
        end
        // Quiet gap, a stray second tile would show up here
        repeat (IDLE_GAP) @(posedge i_clk);
        check_count("o_result_valid pulses", result_count - results_before,
                    int'(cmd.b) * int'(cmd.c));
        check_count("o_tile_done pulses", done_count - done_before, 1);
    endtask

    // ====================
    // Result monitor
    // ====================
    always @(negedge i_clk) begin
        if (i_reset_n) begin
            if (o_tile_done) begin
                done_count++;
                if (!prev_valid) begin
                    other_errors++;
                    $display("Done pulse did not come one cycle after a result");
                end
                if (exp_man_q.size() != 0) begin
                    other_errors++;
                    $display("Done pulse came with %0d results missing", exp_man_q.size());
                end
            end
            if (o_result_valid) begin
                result_count++;
                if (exp_man_q.size() == 0) begin
                    other_errors++;
                    $display("Result appeared while no result was expected");
                end else begin
                    check_mantissa("o_result_mantissa", o_result_mantissa, exp_man_q.pop_front());
                    check_exponent("o_result_exponent", o_result_exponent, exp_exp_q.pop_front());
                end
            end
            prev_valid = o_result_valid;
        end
    end

    always @(posedge i_clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("Timeout after %0d cycles, the run did not complete", timeout_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ====================
    // Main sequence
    // ====================
    initial begin
        void'($urandom(32'h7ce2_66da));
        i_reset_n = 1'b0;
        i_tile_en = 1'b0;
        i_dim_b = '0;
        i_dim_c = '0;
        i_dim_v = '0;
        i_left_base_addr = '0;
        i_right_base_addr = '0;
        prev_valid = 1'b0;
        load_commands();
        timeout_limit = RESET_CYCLES + 50;
        for (int n = 0; n < NUM_CMDS; n++) begin
            timeout_limit += tile_bound(cmd_table[n]) + cmd_table[n].hold + IDLE_GAP + 2;
        end
        fill_memory();
        // Groups at 0, 10, 40, 5 against a zero right NV
        mem_exp[0] = {8'd5, 8'd40, 8'd10, 8'd0};
        mem_exp[1] = '0;
        // Left NV at v=2 of the V=4 tile, far above its neighbours
        mem_exp[4] = {4{8'd60}};

        repeat (RESET_CYCLES) begin
            @(negedge i_clk);
            check_quiet_outputs();
        end
        @(posedge i_clk);
        #DRIVE_DELAY;
        i_reset_n = 1'b1;
        repeat (3) begin
            @(negedge i_clk);
            check_quiet_outputs();
        end

        for (int n = 0; n < NUM_CMDS; n++) begin
            run_tile(n);
        end

        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/bcv_loop_sequencer.sv
/*
 * BCV loop sequencer
 * Accepts a tile on the rising edge of the enable, then walks
 * b (outer), c (middle) and v (inner), issuing index load, capture
 * and launch strobes for each v and a return strobe per (b,c)
 */
`timescale 1ns/1ps
`default_nettype none

module bcv_loop_sequencer
    import gfp8_bcv_pkg::*;
(
    input  wire logic i_clk,
    input  wire logic i_reset_n,
    input  wire logic i_tile_en,
    input  wire dim_t i_dim_b,
    input  wire dim_t i_dim_c,
    input  wire dim_t i_dim_v,
    input  wire logic i_dot_valid,
    output logic      o_tile_start,
    output logic      o_index_load,
    output logic      o_capture,
    output logic      o_launch,
    output logic      o_first,
    output logic      o_return,
    output logic      o_tile_done,
    output dim_t      o_b_idx,
    output dim_t      o_c_idx,
    output dim_t      o_v_idx,
    output dim_t      o_dim_v
);

    typedef enum logic [2:0] {
        IDLE,
        INDEX,
        CAPTURE,
        LAUNCH,
        COMPUTE,
        ACCUM,
        RETURN,
        DONE
    } state_t;

    state_t state_q;
    state_t state_d;

    logic tile_en_q;
    logic tile_rise;
    logic tile_done_q;

    // Captured tile dimensions
    dim_t dim_b_q;
    dim_t dim_c_q;
    dim_t dim_v_q;

    dim_t b_idx;
    dim_t c_idx;
    dim_t v_idx;

    logic last_b;
    logic last_c;
    logic last_v;

    // Only a fresh edge starts a tile, a held enable is ignored
    assign tile_rise = i_tile_en && !tile_en_q;

    assign last_b = (b_idx == dim_b_q - 8'd1);
    assign last_c = (c_idx == dim_c_q - 8'd1);
    assign last_v = (v_idx == dim_v_q - 8'd1);

    // ====================
    // Next state
    // ====================
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (tile_rise) state_d = INDEX;
            INDEX:   state_d = CAPTURE;
            CAPTURE: state_d = LAUNCH;
            LAUNCH:  state_d = COMPUTE;
            // Wait out the dot pipeline
            COMPUTE: if (i_dot_valid) state_d = ACCUM;
            ACCUM:   state_d = last_v ? RETURN : INDEX;
            RETURN:  state_d = (last_b && last_c) ? DONE : INDEX;
            DONE:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            state_q     <= IDLE;
            tile_en_q   <= 1'b0;
            tile_done_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            tile_en_q   <= i_tile_en;
            // Done trails the last result by one cycle
            tile_done_q <= (state_q == DONE);
        end
    end

    // ====================
    // Loop indices
    // ====================
    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            dim_b_q <= '0;
            dim_c_q <= '0;
            dim_v_q <= '0;
            b_idx   <= '0;
            c_idx   <= '0;
            v_idx   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (tile_rise) begin
                        dim_b_q <= i_dim_b;
                        dim_c_q <= i_dim_c;
                        dim_v_q <= i_dim_v;
                        b_idx   <= '0;
                        c_idx   <= '0;
                        v_idx   <= '0;
                    end
                end
                ACCUM: begin
                    if (!last_v) begin
                        v_idx <= v_idx + 8'd1;
                    end
                end
                RETURN: begin
                    v_idx <= '0;
                    // c is the faster index, b steps when c wraps
                    if (!(last_b && last_c)) begin
                        if (last_c) begin
                            c_idx <= '0;
                            b_idx <= b_idx + 8'd1;
                        end else begin
                            c_idx <= c_idx + 8'd1;
                        end
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Strobes decoded from the registered state
    assign o_tile_start = (state_q == IDLE) && tile_rise;
    assign o_index_load = (state_q == INDEX);
    assign o_capture    = (state_q == CAPTURE);
    assign o_launch     = (state_q == LAUNCH);
    assign o_return     = (state_q == RETURN);
    assign o_first      = (v_idx == 8'd0);
    assign o_tile_done  = tile_done_q;

    assign o_b_idx = b_idx;
    assign o_c_idx = c_idx;
    assign o_v_idx = v_idx;
    assign o_dim_v = dim_v_q;

endmodule

`default_nettype wire

//--- verilog/gfp8_bcv_pkg.sv
/*
 * GFP8 BCV shared definitions
 * Widths for loop indices, tile addresses, mantissas and exponents,
 * plus the exponent-aligned add used by the dot pipeline, the V-loop
 * accumulator and the testbench model
 */
`default_nettype none

package gfp8_bcv_pkg;

    // ====================
    // Widths with meaning
    // ====================
    typedef logic [7:0]         dim_t;        // Loop dimension or index
    typedef logic [8:0]         line_addr_t;  // Tile line address, 4 lines per NV
    typedef logic [6:0]         nv_idx_t;     // 128 NVs in tile memory
    typedef logic signed [7:0]  elem_t;       // One GFP8 mantissa element
    typedef logic signed [7:0]  gexp_t;       // Block exponent
    typedef logic signed [31:0] mant_t;       // Accumulated mantissa

    // Shift distances above this flush the operand to zero
    localparam logic [7:0] ALIGN_LIMIT = 8'd31;

    // ====================
    // Aligned add
    // ====================
    // Sum of two (mantissa, exponent) pairs at the larger exponent
    function automatic void align_add(
        input  mant_t a_man,
        input  gexp_t a_exp,
        input  mant_t b_man,
        input  gexp_t b_exp,
        output mant_t sum_man,
        output gexp_t sum_exp
    );
        gexp_t      max_exp;
        logic [7:0] a_shift;
        logic [7:0] b_shift;
        mant_t      a_aligned;
        mant_t      b_aligned;

        max_exp = (a_exp > b_exp) ? a_exp : b_exp;
        // Distance taken as 8-bit unsigned, wraps on extreme exponents
        a_shift = max_exp - a_exp;
        b_shift = max_exp - b_exp;
        // Signed zero keeps the shift arithmetic
        a_aligned = (a_shift > ALIGN_LIMIT) ? 32'sd0 : (a_man >>> a_shift);
        b_aligned = (b_shift > ALIGN_LIMIT) ? 32'sd0 : (b_man >>> b_shift);
        sum_man = a_aligned + b_aligned;
        sum_exp = max_exp;
    endfunction

endpackage

`default_nettype wire

//--- verilog/gfp8_bcv_top.sv
/*
 * GFP8 BCV tile engine
 * Sequencer, NV fetch, dot pipeline and V-loop accumulator
 */
`timescale 1ns/1ps
`default_nettype none

module gfp8_bcv_top
    import gfp8_bcv_pkg::*;
#(
    parameter int  NV_GROUPS   = 4,
    parameter int  GROUP_ELEMS = 32,
    localparam int EXP_W       = NV_GROUPS * 8,
    localparam int MAN_W       = NV_GROUPS * GROUP_ELEMS * 8
) (
    input  wire logic             i_clk,
    input  wire logic             i_reset_n,
    input  wire logic             i_tile_en,
    input  wire dim_t             i_dim_b,
    input  wire dim_t             i_dim_c,
    input  wire dim_t             i_dim_v,
    input  wire line_addr_t       i_left_base_addr,
    input  wire line_addr_t       i_right_base_addr,
    output logic                  o_tile_done,
    output nv_idx_t               o_nv_left_rd_idx,
    input  wire logic [EXP_W-1:0] i_nv_left_exp,
    input  wire logic [MAN_W-1:0] i_nv_left_man,
    output nv_idx_t               o_nv_right_rd_idx,
    input  wire logic [EXP_W-1:0] i_nv_right_exp,
    input  wire logic [MAN_W-1:0] i_nv_right_man,
    output mant_t                 o_result_mantissa,
    output gexp_t                 o_result_exponent,
    output logic                  o_result_valid
);

    // Sequencer strobes and indices
    logic tile_start;
    logic index_load;
    logic capture;
    logic launch;
    logic first;
    logic return_pulse;
    dim_t b_idx;
    dim_t c_idx;
    dim_t v_idx;
    dim_t dim_v;

    // Captured NV buffers
    logic [EXP_W-1:0] left_exp;
    logic [EXP_W-1:0] right_exp;
    logic [MAN_W-1:0] left_man;
    logic [MAN_W-1:0] right_man;

    // Dot result
    logic  dot_valid;
    mant_t dot_mantissa;
    gexp_t dot_exponent;

    bcv_loop_sequencer u_seq (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_tile_en    (i_tile_en),
        .i_dim_b      (i_dim_b),
        .i_dim_c      (i_dim_c),
        .i_dim_v      (i_dim_v),
        .i_dot_valid  (dot_valid),
        .o_tile_start (tile_start),
        .o_index_load (index_load),
        .o_capture    (capture),
        .o_launch     (launch),
        .o_first      (first),
        .o_return     (return_pulse),
        .o_tile_done  (o_tile_done),
        .o_b_idx      (b_idx),
        .o_c_idx      (c_idx),
        .o_v_idx      (v_idx),
        .o_dim_v      (dim_v)
    );

    nv_fetch #(
        .NV_GROUPS   (NV_GROUPS),
        .GROUP_ELEMS (GROUP_ELEMS)
    ) u_fetch (
        .i_clk             (i_clk),
        .i_reset_n         (i_reset_n),
        .i_tile_start      (tile_start),
        .i_index_load      (index_load),
        .i_capture         (capture),
        .i_left_base_addr  (i_left_base_addr),
        .i_right_base_addr (i_right_base_addr),
        .i_b_idx           (b_idx),
        .i_c_idx           (c_idx),
        .i_v_idx           (v_idx),
        .i_dim_v           (dim_v),
        .i_nv_left_exp     (i_nv_left_exp),
        .i_nv_right_exp    (i_nv_right_exp),
        .i_nv_left_man     (i_nv_left_man),
        .i_nv_right_man    (i_nv_right_man),
        .o_nv_left_rd_idx  (o_nv_left_rd_idx),
        .o_nv_right_rd_idx (o_nv_right_rd_idx),
        .o_left_exp        (left_exp),
        .o_right_exp       (right_exp),
        .o_left_man        (left_man),
        .o_right_man       (right_man)
    );

    nv_dot_pipe #(
        .NV_GROUPS   (NV_GROUPS),
        .GROUP_ELEMS (GROUP_ELEMS)
    ) u_dot (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_launch       (launch),
        .i_left_exp     (left_exp),
        .i_right_exp    (right_exp),
        .i_left_man     (left_man),
        .i_right_man    (right_man),
        .o_dot_valid    (dot_valid),
        .o_dot_mantissa (dot_mantissa),
        .o_dot_exponent (dot_exponent)
    );

    vloop_accumulator u_acc (
        .i_clk             (i_clk),
        .i_reset_n         (i_reset_n),
        .i_dot_valid       (dot_valid),
        .i_first           (first),
        .i_return          (return_pulse),
        .i_dot_mantissa    (dot_mantissa),
        .i_dot_exponent    (dot_exponent),
        .o_result_mantissa (o_result_mantissa),
        .o_result_exponent (o_result_exponent),
        .o_result_valid    (o_result_valid)
    );

endmodule

`default_nettype wire

//--- verilog/nv_dot_pipe.sv
/*
 * NV dot product pipeline
 * Four stages: operand latch, elementwise products, per-group sums
 * with group exponents, then an aligned fold across the groups
 */
`timescale 1ns/1ps
`default_nettype none

module nv_dot_pipe
    import gfp8_bcv_pkg::*;
#(
    parameter int  NV_GROUPS   = 4,
    parameter int  GROUP_ELEMS = 32,
    localparam int EXP_W       = NV_GROUPS * 8,
    localparam int MAN_W       = NV_GROUPS * GROUP_ELEMS * 8
) (
    input  wire logic             i_clk,
    input  wire logic             i_reset_n,
    input  wire logic             i_launch,
    input  wire logic [EXP_W-1:0] i_left_exp,
    input  wire logic [EXP_W-1:0] i_right_exp,
    input  wire logic [MAN_W-1:0] i_left_man,
    input  wire logic [MAN_W-1:0] i_right_man,
    output logic                  o_dot_valid,
    output mant_t                 o_dot_mantissa,
    output gexp_t                 o_dot_exponent
);

    localparam int DOT_LATENCY = 4;

    // Valid bits follow the data, one per stage
    logic [DOT_LATENCY-1:0] valid_sr;

    // Stage 1 operands
    logic [EXP_W-1:0] s1_lexp;
    logic [EXP_W-1:0] s1_rexp;
    logic [MAN_W-1:0] s1_lman;
    logic [MAN_W-1:0] s1_rman;

    // Stage 2 products
    logic signed [15:0] s2_prod [NV_GROUPS][GROUP_ELEMS];
    logic [EXP_W-1:0]   s2_lexp;
    logic [EXP_W-1:0]   s2_rexp;

    // Stage 3 group results
    mant_t grp_sum [NV_GROUPS];
    mant_t s3_gsum [NV_GROUPS];
    gexp_t s3_gexp [NV_GROUPS];

    // Stage 4 fold chain
    mant_t chain_man [NV_GROUPS];
    gexp_t chain_exp [NV_GROUPS];

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[DOT_LATENCY-2:0], i_launch};
        end
    end

    // ====================
    // Stages 1 and 2
    // ====================
    always_ff @(posedge i_clk) begin
        if (i_launch) begin
            s1_lexp <= i_left_exp;
            s1_rexp <= i_right_exp;
            s1_lman <= i_left_man;
            s1_rman <= i_right_man;
        end
        s2_lexp <= s1_lexp;
        s2_rexp <= s1_rexp;
        // Element e of group g sits at byte g*GROUP_ELEMS+e
        for (int g = 0; g < NV_GROUPS; g++) begin
            for (int e = 0; e < GROUP_ELEMS; e++) begin
                s2_prod[g][e] <= elem_t'(s1_lman[(g*GROUP_ELEMS+e)*8 +: 8])
                               * elem_t'(s1_rman[(g*GROUP_ELEMS+e)*8 +: 8]);
            end
        end
    end

    // ====================
    // Stage 3
    // ====================
    always_comb begin
        for (int g = 0; g < NV_GROUPS; g++) begin
            grp_sum[g] = '0;
            for (int e = 0; e < GROUP_ELEMS; e++) begin
                grp_sum[g] = grp_sum[g] + mant_t'(s2_prod[g][e]);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        for (int g = 0; g < NV_GROUPS; g++) begin
            s3_gsum[g] <= grp_sum[g];
            // Exponents add with 8-bit wrap
            s3_gexp[g] <= s2_lexp[g*8 +: 8] + s2_rexp[g*8 +: 8];
        end
    end

    // ====================
    // Stage 4
    // ====================
    // Fold groups in order, starting from group 0
    always_comb begin
        chain_man[0] = s3_gsum[0];
        chain_exp[0] = s3_gexp[0];
        for (int g = 1; g < NV_GROUPS; g++) begin
            align_add(chain_man[g-1], chain_exp[g-1], s3_gsum[g], s3_gexp[g],
                      chain_man[g], chain_exp[g]);
        end
    end

    always_ff @(posedge i_clk) begin
        o_dot_mantissa <= chain_man[NV_GROUPS-1];
        o_dot_exponent <= chain_exp[NV_GROUPS-1];
    end

    assign o_dot_valid = valid_sr[DOT_LATENCY-1];

endmodule

`default_nettype wire

//--- verilog/nv_fetch.sv
/*
 * NV fetch
 * Forms the left and right NV indices from the base addresses and
 * loop indices, registers them toward tile memory, and captures the
 * returned Native Vectors into local buffers
 */
`timescale 1ns/1ps
`default_nettype none

module nv_fetch
    import gfp8_bcv_pkg::*;
#(
    parameter int  NV_GROUPS   = 4,
    parameter int  GROUP_ELEMS = 32,
    localparam int EXP_W       = NV_GROUPS * 8,
    localparam int MAN_W       = NV_GROUPS * GROUP_ELEMS * 8
) (
    input  wire logic             i_clk,
    input  wire logic             i_reset_n,
    input  wire logic             i_tile_start,
    input  wire logic             i_index_load,
    input  wire logic             i_capture,
    input  wire line_addr_t       i_left_base_addr,
    input  wire line_addr_t       i_right_base_addr,
    input  wire dim_t             i_b_idx,
    input  wire dim_t             i_c_idx,
    input  wire dim_t             i_v_idx,
    input  wire dim_t             i_dim_v,
    input  wire logic [EXP_W-1:0] i_nv_left_exp,
    input  wire logic [EXP_W-1:0] i_nv_right_exp,
    input  wire logic [MAN_W-1:0] i_nv_left_man,
    input  wire logic [MAN_W-1:0] i_nv_right_man,
    output nv_idx_t               o_nv_left_rd_idx,
    output nv_idx_t               o_nv_right_rd_idx,
    output logic [EXP_W-1:0]      o_left_exp,
    output logic [EXP_W-1:0]      o_right_exp,
    output logic [MAN_W-1:0]      o_left_man,
    output logic [MAN_W-1:0]      o_right_man
);

    line_addr_t left_base_q;
    line_addr_t right_base_q;

    // Wide enough for b*V + v before the modulo-128 truncation
    logic [15:0] left_lin;
    logic [15:0] right_lin;

    // Base is in lines, drop two bits to get NV units
    assign left_lin  = 16'(left_base_q[8:2]) + i_b_idx * i_dim_v + 16'(i_v_idx);
    assign right_lin = 16'(right_base_q[8:2]) + i_c_idx * i_dim_v + 16'(i_v_idx);

    // ====================
    // Index registers
    // ====================
    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            left_base_q       <= '0;
            right_base_q      <= '0;
            o_nv_left_rd_idx  <= '0;
            o_nv_right_rd_idx <= '0;
        end else begin
            if (i_tile_start) begin
                left_base_q  <= i_left_base_addr;
                right_base_q <= i_right_base_addr;
            end
            // Breaks the multiply-add path ahead of the memory
            if (i_index_load) begin
                o_nv_left_rd_idx  <= left_lin[6:0];
                o_nv_right_rd_idx <= right_lin[6:0];
            end
        end
    end

    // Whole NV captured in one cycle
    always_ff @(posedge i_clk) begin
        if (i_capture) begin
            o_left_exp  <= i_nv_left_exp;
            o_right_exp <= i_nv_right_exp;
            o_left_man  <= i_nv_left_man;
            o_right_man <= i_nv_right_man;
        end
    end

endmodule

`default_nettype wire

//--- verilog/vloop_accumulator.sv
/*
 * V-loop accumulator
 * Sums the V dot results of one (b,c) pair with exponent alignment
 * and registers the total to the result outputs on return
 */
`timescale 1ns/1ps
`default_nettype none

module vloop_accumulator
    import gfp8_bcv_pkg::*;
(
    input  wire logic  i_clk,
    input  wire logic  i_reset_n,
    input  wire logic  i_dot_valid,
    input  wire logic  i_first,
    input  wire logic  i_return,
    input  wire mant_t i_dot_mantissa,
    input  wire gexp_t i_dot_exponent,
    output mant_t      o_result_mantissa,
    output gexp_t      o_result_exponent,
    output logic       o_result_valid
);

    mant_t acc_man;
    gexp_t acc_exp;
    mant_t sum_man;
    gexp_t sum_exp;

    always_comb begin
        align_add(acc_man, acc_exp, i_dot_mantissa, i_dot_exponent, sum_man, sum_exp);
    end

    // First v overwrites, so no clear between pairs
    always_ff @(posedge i_clk) begin
        if (i_dot_valid) begin
            acc_man <= i_first ? i_dot_mantissa : sum_man;
            acc_exp <= i_first ? i_dot_exponent : sum_exp;
        end
        if (i_return) begin
            o_result_mantissa <= acc_man;
            o_result_exponent <= acc_exp;
        end
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            o_result_valid <= 1'b0;
        end else begin
            o_result_valid <= i_return;
        end
    end

endmodule

`default_nettype wire
